//--- hw/mduPkg.sv
// Shared widths and encodings for the multiply/divide unit, imported by every RTL file
package mduPkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int XLEN = 64;                 // Integer register width
  localparam int WLEN = 32;                 // W-type operand width
  localparam int CNTW = $clog2(XLEN) + 1;   // Holds 64 itself, so 7 bits

  //////////////////////////////
  // Operations
  //////////////////////////////

  // Funct3 of the M-extension opcodes
  typedef enum logic [2:0] {
    opMul    = 3'b000,  // Low half of product
    opMulh   = 3'b001,  // High half, signed x signed
    opMulhsu = 3'b010,  // High half, signed x unsigned
    opMulhu  = 3'b011,  // High half, unsigned x unsigned
    opDiv    = 3'b100,
    opDivu   = 3'b101,
    opRem    = 3'b110,
    opRemu   = 3'b111
  } mduOp_t;

  //////////////////////////////
  // Divider control
  //////////////////////////////

  typedef enum logic [1:0] {
    divIdle = 2'b00,   // Waiting for a divide in Execute
    divPrep = 2'b01,   // Operand magnitudes and signs captured
    divIter = 2'b10,   // One quotient bit per cycle
    divDone = 2'b11    // Busy dropped, waiting for Execute to advance
  } divState_t;

endpackage

//--- hw/mulUnit.sv
// Signed/unsigned 64x64 multiplier with product registered into Memory, instantiated by mdu
`timescale 1ns/1ps

module mulUnit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          StallM,   // Hold product register
  input  logic                          FlushM,   // Clear product register
  input  logic [mduPkg::XLEN-1:0]       srcA,     // Gated operand A
  input  logic [mduPkg::XLEN-1:0]       srcB,     // Gated operand B
  input  mduPkg::mduOp_t                Funct3E,  // Operation in Execute
  output logic [2*mduPkg::XLEN-1:0]     ProdM     // Full product in Memory
);

  import mduPkg::*;

  logic                    signA, signB;  // Operand treated as signed
  logic signed [XLEN:0]    aExt, bExt;    // One extra bit for sign or zero
  logic signed [2*XLEN+1:0] prodFull;     // 65x65 product
  logic [2*XLEN-1:0]       prodE;

  //////////////////////////////
  // Operand extension
  //////////////////////////////

  // mulh is signed on both sides, mulhsu only on A
  // mul takes the low half so extension choice is irrelevant there
  always_comb begin
    signA = (Funct3E == opMulh) | (Funct3E == opMulhsu);
    signB = (Funct3E == opMulh);
  end

  assign aExt = {signA & srcA[XLEN-1], srcA};
  assign bExt = {signB & srcB[XLEN-1], srcB};

  //////////////////////////////
  // Multiply
  //////////////////////////////

  assign prodFull = aExt * bExt;           // Both signed, so sign-extended to 130 bits
  assign prodE    = prodFull[2*XLEN-1:0];  // Top two bits are only sign copies

  // Execute to Memory product register
  always_ff @(posedge clk) begin
    if (rst | FlushM) begin
      ProdM <= '0;
    end else if (~StallM) begin
      ProdM <= prodE;
    end
  end

endmodule

//--- hw/divFsm.sv
// Divider sequencing FSM; raises the Execute busy stall and steers counter and datapath
`timescale 1ns/1ps

module divFsm (
  input  logic clk,
  input  logic rst,
  input  logic FlushE,      // Abandon divide in Execute
  input  logic StallM,      // Memory stage held
  input  logic IntDivE,     // Divide or remainder in Execute
  input  logic MDUActiveE,  // M instruction in Execute
  input  logic lastIter,    // Final shift/subtract step this cycle
  output logic DivBusyE,    // Stall Execute
  output logic prepStart,   // Capture operands in datapath
  output logic cntLoad,     // Load iteration counter
  output logic iterEn,      // Advance one quotient bit
  output logic doneM        // Move results into Memory registers
);

  import mduPkg::*;

  divState_t state, nextState;
  logic      startDiv;

  assign startDiv = IntDivE & MDUActiveE;

  //////////////////////////////
  // State register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst | FlushE) begin  // Flush wins from any state
      state <= divIdle;
    end else begin
      state <= nextState;
    end
  end

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      divIdle: if (startDiv) nextState = divPrep;
      divPrep: nextState = divIter;
      divIter: if (lastIter) nextState = divDone;
      divDone: if (~StallM) nextState = divIdle;  // Instruction leaves Execute
      default: nextState = divIdle;
    endcase
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Busy from the start cycle through the last iteration
  assign DivBusyE  = ((state == divIdle) & startDiv) | (state == divPrep) | (state == divIter);
  assign prepStart = (state == divPrep);
  assign cntLoad   = (state == divPrep);  // Same cycle as operand capture
  assign iterEn    = (state == divIter);
  assign doneM     = (state == divDone) & ~StallM;  // Edge where the divide enters M

endmodule

//--- hw/divCounter.sv
// Iteration counter for the restoring divider, flags the final shift/subtract step
`timescale 1ns/1ps

module divCounter (
  input  logic clk,
  input  logic rst,
  input  logic cntLoad,   // Start of a divide
  input  logic iterEn,    // One step taken
  input  logic W64E,      // 32-bit divide
  output logic lastIter   // Step in progress is the final one
);

  import mduPkg::*;

  logic [CNTW-1:0] count;  // Steps still to do, including current

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (cntLoad) begin
      count <= W64E ? CNTW'(WLEN) : CNTW'(XLEN);  // W-type needs half the steps
    end else if (iterEn) begin
      count <= count - 1'b1;
    end
  end

  // Only sampled by the FSM while iterating
  assign lastIter = (count == CNTW'(1));

endmodule

//--- hw/divDatapath.sv
// Restoring radix-2 divide datapath with sign handling and RISC-V divide-by-zero results
`timescale 1ns/1ps

module divDatapath (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     prepStart,  // Capture operands
  input  logic                     iterEn,     // One shift/subtract step
  input  logic                     doneM,      // Load Memory stage results
  input  logic                     W64E,       // 32-bit operands
  input  mduPkg::mduOp_t           Funct3E,
  input  logic [mduPkg::XLEN-1:0]  srcA,       // Dividend
  input  logic [mduPkg::XLEN-1:0]  srcB,       // Divisor
  output logic [mduPkg::XLEN-1:0]  QuotM,
  output logic [mduPkg::XLEN-1:0]  RemM
);

  import mduPkg::*;

  logic            signedOp;
  logic [XLEN-1:0] aTrunc, bTrunc;     // After W-type truncation and extension
  logic            aNeg, bNeg;
  logic [XLEN-1:0] aMag, bMag;
  logic [XLEN-1:0] quoSeed;

  logic [XLEN-1:0] quoReg;             // Dividend shifting out, quotient shifting in
  logic [XLEN-1:0] remReg;             // Partial remainder
  logic [XLEN-1:0] divisorReg;         // Divisor magnitude
  logic [XLEN-1:0] dividendReg;        // Kept for divide by zero
  logic            quoNeg, remNeg, divZero;

  logic [XLEN:0]   remShift, remDiff;  // Extra bit for borrow
  logic            stepNeg;
  logic [XLEN-1:0] quoFixed, remFixed;

  //////////////////////////////
  // Operand preparation
  //////////////////////////////

  assign signedOp = (Funct3E == opDiv) | (Funct3E == opRem);  // divu/remu are unsigned

  // W-type uses only the low word, extended as the op dictates
  assign aTrunc = W64E ? {{(XLEN-WLEN){signedOp & srcA[WLEN-1]}}, srcA[WLEN-1:0]} : srcA;
  assign bTrunc = W64E ? {{(XLEN-WLEN){signedOp & srcB[WLEN-1]}}, srcB[WLEN-1:0]} : srcB;

  assign aNeg = signedOp & aTrunc[XLEN-1];
  assign bNeg = signedOp & bTrunc[XLEN-1];
  assign aMag = aNeg ? -aTrunc : aTrunc;
  assign bMag = bNeg ? -bTrunc : bTrunc;

  // 32-bit dividend sits at the top so its MSB shifts out first
  assign quoSeed = W64E ? {aMag[WLEN-1:0], {(XLEN-WLEN){1'b0}}} : aMag;

  // Sign and zero flags
  always_ff @(posedge clk) begin
    if (rst) begin
      quoNeg  <= 1'b0;
      remNeg  <= 1'b0;
      divZero <= 1'b0;
    end else if (prepStart) begin
      quoNeg  <= aNeg ^ bNeg;
      remNeg  <= aNeg;                  // Remainder follows the dividend
      divZero <= (bTrunc == '0);
    end
  end

  //////////////////////////////
  // Shift/subtract step
  //////////////////////////////

  assign remShift = {remReg, quoReg[XLEN-1]};
  assign remDiff  = remShift - {1'b0, divisorReg};
  assign stepNeg  = remDiff[XLEN];      // Borrow means restore

  always_ff @(posedge clk) begin
    if (prepStart) begin
      quoReg      <= quoSeed;
      remReg      <= '0;
      divisorReg  <= bMag;
      dividendReg <= aTrunc;
    end else if (iterEn) begin
      quoReg <= {quoReg[XLEN-2:0], ~stepNeg};                   // New quotient bit
      remReg <= stepNeg ? remShift[XLEN-1:0] : remDiff[XLEN-1:0];
    end
  end

  //////////////////////////////
  // Sign fixup and M registers
  //////////////////////////////

  // Zero divisor gives all ones and the raw dividend
  // Overflow case -2^63 / -1 comes out as the dividend unchanged
  assign quoFixed = divZero ? '1 : (quoNeg ? -quoReg : quoReg);
  assign remFixed = divZero ? dividendReg : (remNeg ? -remReg : remReg);

  always_ff @(posedge clk) begin
    if (rst) begin
      QuotM <= '0;
      RemM  <= '0;
    end else if (doneM) begin
      QuotM <= quoFixed;
      RemM  <= remFixed;
    end
  end

endmodule

//--- hw/mdu.sv
// Top of the M-extension unit; sits in Execute/Memory and returns the result in Writeback
`timescale 1ns/1ps

module mdu (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     StallM,
  input  logic                     StallW,
  input  logic                     FlushE,
  input  logic                     FlushM,
  input  logic                     FlushW,
  input  logic [mduPkg::XLEN-1:0]  ForwardedSrcAE,  // From forwarding mux
  input  logic [mduPkg::XLEN-1:0]  ForwardedSrcBE,
  input  mduPkg::mduOp_t           Funct3E,
  input  mduPkg::mduOp_t           Funct3M,
  input  logic                     IntDivE,         // div/rem family in Execute
  input  logic                     W64E,            // W-type in Execute
  input  logic                     MDUActiveE,      // Any M instruction in Execute
  output logic [mduPkg::XLEN-1:0]  MDUResultW,
  output logic                     DivBusyE         // Stall to the pipeline
);

  import mduPkg::*;

  logic [XLEN-1:0]   srcA, srcB;            // Gated operands
  logic [2*XLEN-1:0] ProdM;
  logic [XLEN-1:0]   QuotM, RemM;
  logic [XLEN-1:0]   PrelimResultM;         // Before W-type extension
  logic [XLEN-1:0]   MDUResultM;
  logic              W64M;
  logic              prepStart, cntLoad, iterEn, doneM, lastIter;

  // Zero inputs keep the multiplier quiet when idle
  assign srcA = ForwardedSrcAE & {XLEN{MDUActiveE}};
  assign srcB = ForwardedSrcBE & {XLEN{MDUActiveE}};

  //////////////////////////////
  // Multiplier
  //////////////////////////////

  mulUnit mulU (
    .clk, .rst, .StallM, .FlushM, .srcA, .srcB, .Funct3E, .ProdM
  );

  //////////////////////////////
  // Divider
  //////////////////////////////

  divFsm divCtl (
    .clk, .rst, .FlushE, .StallM, .IntDivE, .MDUActiveE, .lastIter,
    .DivBusyE, .prepStart, .cntLoad, .iterEn, .doneM
  );

  divCounter divCnt (
    .clk, .rst, .cntLoad, .iterEn, .W64E, .lastIter
  );

  divDatapath divDp (
    .clk, .rst, .prepStart, .iterEn, .doneM, .W64E, .Funct3E,
    .srcA, .srcB, .QuotM, .RemM
  );

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    case (Funct3M)
      opMul:    PrelimResultM = ProdM[XLEN-1:0];       // Low half
      opMulh,
      opMulhsu,
      opMulhu:  PrelimResultM = ProdM[2*XLEN-1:XLEN];  // High half
      opDiv,
      opDivu:   PrelimResultM = QuotM;
      default:  PrelimResultM = RemM;                  // rem, remu
    endcase
  end

  // W-type flag follows the instruction into M
  always_ff @(posedge clk) begin
    if (rst | FlushM) begin
      W64M <= 1'b0;
    end else if (~StallM) begin
      W64M <= W64E;
    end
  end

  assign MDUResultM = W64M ? {{(XLEN-WLEN){PrelimResultM[WLEN-1]}}, PrelimResultM[WLEN-1:0]}
                           : PrelimResultM;

  //////////////////////////////
  // Writeback register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst | FlushW) begin   // Flush beats stall
      MDUResultW <= '0;
    end else if (~StallW) begin
      MDUResultW <= MDUResultM;
    end
  end

endmodule

//--- verif/mduVectors.svh
// Directed multiply/divide vectors with expected results, included inside the testbench module
`ifndef MDU_VECTORS_SVH
`define MDU_VECTORS_SVH

// One row: operation, operands, W-type flag, expected Writeback value
typedef struct packed {
  mduOp_t      op;
  logic [63:0] a;
  logic [63:0] b;
  logic        w;
  logic [63:0] exp;
} vecRow_t;

localparam int NUMROWS = 32;

vecRow_t vecTable [NUMROWS];

task automatic loadVectors();
  // Multiplies, run back to back
  vecTable[0]  = '{opMul,    64'h3, 64'h5, 1'b0, 64'hF};
  vecTable[1]  = '{opMul,    '1, '1, 1'b0, 64'h1};                      // -1 * -1
  vecTable[2]  = '{opMulh,   '1, '1, 1'b0, 64'h0};
  vecTable[3]  = '{opMulhu,  '1, '1, 1'b0, 64'hFFFFFFFFFFFFFFFE};
  vecTable[4]  = '{opMulhsu, '1, '1, 1'b0, 64'hFFFFFFFFFFFFFFFF};       // -(2^64-1)
  vecTable[5]  = '{opMulh,   64'h7FFFFFFFFFFFFFFF, 64'h7FFFFFFFFFFFFFFF, 1'b0,
                   64'h3FFFFFFFFFFFFFFF};                                // Max squared
  vecTable[6]  = '{opMulh,   64'h8000000000000000, 64'h8000000000000000, 1'b0,
                   64'h4000000000000000};
  vecTable[7]  = '{opMul,    64'h0, 64'h1234, 1'b0, 64'h0};
  vecTable[8]  = '{opMulhu,  64'h8000000000000000, 64'h2, 1'b0, 64'h1};
  vecTable[9]  = '{opMulhsu, 64'h8000000000000000, 64'h2, 1'b0, 64'hFFFFFFFFFFFFFFFF};
  // W-type multiplies
  vecTable[10] = '{opMul,    64'h7FFFFFFF, 64'h2, 1'b1, 64'hFFFFFFFFFFFFFFFE};
  vecTable[11] = '{opMul,    64'h0000000100000003, 64'h5, 1'b1, 64'hF};  // Upper word ignored
  // Signed and unsigned divides
  vecTable[12] = '{opDiv,    64'd100, 64'd7, 1'b0, 64'hE};
  vecTable[13] = '{opRem,    64'd100, 64'd7, 1'b0, 64'h2};
  vecTable[14] = '{opDiv,    -64'sd100, 64'd7, 1'b0, 64'hFFFFFFFFFFFFFFF2};
  vecTable[15] = '{opRem,    -64'sd100, 64'd7, 1'b0, 64'hFFFFFFFFFFFFFFFE};
  vecTable[16] = '{opDivu,   '1, 64'h2, 1'b0, 64'h7FFFFFFFFFFFFFFF};
  vecTable[17] = '{opRemu,   '1, 64'h2, 1'b0, 64'h1};
  // Divide by zero
  vecTable[18] = '{opDiv,    64'h123, 64'h0, 1'b0, '1};
  vecTable[19] = '{opRem,    64'h123, 64'h0, 1'b0, 64'h123};
  vecTable[20] = '{opDivu,   64'h0, 64'h0, 1'b0, '1};
  vecTable[21] = '{opRemu,   64'd55, 64'h0, 1'b0, 64'd55};
  // Most negative over minus one
  vecTable[22] = '{opDiv,    64'h8000000000000000, '1, 1'b0, 64'h8000000000000000};
  vecTable[23] = '{opRem,    64'h8000000000000000, '1, 1'b0, 64'h0};
  // W-type divides
  vecTable[24] = '{opDiv,    64'hFFFFFFF9, 64'h2, 1'b1, 64'hFFFFFFFFFFFFFFFD};  // -7 / 2
  vecTable[25] = '{opRem,    64'hFFFFFFF9, 64'h2, 1'b1, 64'hFFFFFFFFFFFFFFFF};
  vecTable[26] = '{opDivu,   64'h80000000, 64'h2, 1'b1, 64'h40000000};
  vecTable[27] = '{opDiv,    64'h80000000, 64'hFFFFFFFF, 1'b1, 64'hFFFFFFFF80000000};
  vecTable[28] = '{opRemu,   64'hABCD00000000000A, 64'h3, 1'b1, 64'h1};
  // Multiply straight after a divide
  vecTable[29] = '{opMulhu,  64'h100000000, 64'h100000000, 1'b0, 64'h1};
  vecTable[30] = '{opDiv,    64'h5, 64'h0, 1'b1, '1};
  vecTable[31] = '{opRem,    64'hFFFFFFFF80000001, 64'h0, 1'b1, 64'hFFFFFFFF80000001};
endtask

`endif

//--- verif/mduTb.sv
// Self-checking testbench for the mdu top level; run from the project root with the file list
`timescale 1ns/1ps

module mduTb;

  import mduPkg::*;

  `include "mduVectors.svh"

  localparam int NUMRAND = 40;
  localparam int LIMIT   = (NUMROWS + NUMRAND + 10) * 70 + 200;  // Cycles before abort

  logic clk = 1'b0;
  logic rst, StallM, StallW, FlushE, FlushM, FlushW;
  logic [63:0] ForwardedSrcAE, ForwardedSrcBE;
  mduOp_t Funct3E, Funct3M;
  logic IntDivE, W64E, MDUActiveE;
  logic [63:0] MDUResultW;
  logic DivBusyE;

  logic [31:0] lfsr = 32'h241a935f;
  int          cycleCount = 0;
  logic        mValid;      // Item sitting in M
  logic [63:0] mExp;

  mdu UUT (.*);

  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > LIMIT) begin
      $display("Simulation ran past its cycle limit without finishing");
      $display("Test failed");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [63:0] randomBits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  // Reference model straight from the M-extension rules
  function automatic logic [63:0] refModel(mduOp_t op, logic [63:0] a, logic [63:0] b,
                                           logic w);
    logic [127:0] ea, eb, prod;
    logic [63:0]  da, db, q, r, res;
    logic         sgn;
    if (!op[2]) begin
      ea   = (op == opMulh || op == opMulhsu) ? {{64{a[63]}}, a} : {64'b0, a};
      eb   = (op == opMulh) ? {{64{b[63]}}, b} : {64'b0, b};
      prod = ea * eb;                                 // Modulo 2^128
      res  = (op == opMul) ? prod[63:0] : prod[127:64];
    end else begin
      sgn = (op == opDiv || op == opRem);
      da  = w ? (sgn ? {{32{a[31]}}, a[31:0]} : {32'b0, a[31:0]}) : a;
      db  = w ? (sgn ? {{32{b[31]}}, b[31:0]} : {32'b0, b[31:0]}) : b;
      if (db == 0) begin
        q = '1;
        r = da;
      end else if (sgn && da == 64'h8000000000000000 && db == '1) begin
        q = da;   // Overflow
        r = '0;
      end else if (sgn) begin
        q = $signed(da) / $signed(db);
        r = $signed(da) % $signed(db);
      end else begin
        q = da / db;
        r = da % db;
      end
      res = op[1] ? r : q;
    end
    if (w) res = {{32{res[31]}}, res[31:0]};
    return res;
  endfunction

  task automatic driveE(input mduOp_t op, input logic [63:0] a, input logic [63:0] b,
                        input logic w);
    ForwardedSrcAE = a;
    ForwardedSrcBE = b;
    Funct3E        = op;
    W64E           = w;
    IntDivE        = op[2];
    MDUActiveE     = 1'b1;
  endtask

  task automatic idleE();
    ForwardedSrcAE = '0;
    ForwardedSrcBE = '0;
    Funct3E        = opMul;
    W64E           = 1'b0;
    IntDivE        = 1'b0;
    MDUActiveE     = 1'b0;
  endtask

  // One clock; the M item lands in W and is checked, E item advances if asked
  task automatic tick(input logic advance, input mduOp_t op, input logic [63:0] exp);
    @(posedge clk);
    #5;
    if (mValid) begin
      check("MDUResultW", MDUResultW, mExp);
    end
    mValid = advance;
    if (advance) begin
      mExp    = exp;
      Funct3M = op;
    end
  endtask

  // Present in E, ride out the busy stall, then advance
  task automatic issue(input mduOp_t op, input logic [63:0] a, input logic [63:0] b,
                       input logic w, input logic [63:0] exp);
    int busyCount;
    int busyExp;
    busyCount = 0;
    busyExp   = op[2] ? (w ? 34 : 66) : 0;  // Start, prep, then 32 or 64 steps
    driveE(op, a, b, w);
    @(negedge clk);
    while (DivBusyE) begin
      busyCount++;
      tick(1'b0, op, exp);
      @(negedge clk);
    end
    check("DivBusyE cycles", 64'(busyCount), 64'(busyExp));
    tick(1'b1, op, exp);
  endtask

  task automatic drain();
    idleE();
    tick(1'b0, opMul, '0);
    tick(1'b0, opMul, '0);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [63:0] ra, rb, rop, rw;
    mduOp_t      op;
    rst = 1'b1;
    {StallM, StallW, FlushE, FlushM, FlushW} = '0;
    idleE();
    Funct3M = opMul;
    mValid  = 1'b0;
    mExp    = '0;
    loadVectors();
    repeat (3) @(posedge clk);
    #5 rst = 1'b0;
    check("DivBusyE", 64'(DivBusyE), 64'h0);
    check("MDUResultW", MDUResultW, 64'h0);

    // Directed table
    for (int i = 0; i < NUMROWS; i++) begin
      check("table row vs model",
            refModel(vecTable[i].op, vecTable[i].a, vecTable[i].b, vecTable[i].w),
            vecTable[i].exp);
      issue(vecTable[i].op, vecTable[i].a, vecTable[i].b, vecTable[i].w, vecTable[i].exp);
    end

    // Random ops with W only on real RV64 W forms
    for (int i = 0; i < NUMRAND; i++) begin
      rop = randomBits(3);
      rw  = randomBits(1);
      ra  = randomBits(64);
      rb  = randomBits(64);
      op = mduOp_t'(rop[2:0]);
      if (op == opMulh || op == opMulhsu || op == opMulhu) rw = '0;
      issue(op, ra, rb, rw[0], refModel(op, ra, rb, rw[0]));
    end
    drain();

    // Two multiplies back to back, then hold and clear W
    driveE(opMul, 64'h3, 64'h5, 1'b0);
    @(posedge clk);
    #5;
    Funct3M = opMul;
    driveE(opMul, 64'h7, 64'h6, 1'b0);
    @(posedge clk);
    #5;
    check("MDUResultW", MDUResultW, 64'hF);
    idleE();
    StallM = 1'b1;  // Product 42 stays in M
    StallW = 1'b1;
    @(posedge clk);
    #5;
    check("MDUResultW", MDUResultW, 64'hF);   // Held over the waiting 42
    StallW = 1'b0;
    @(posedge clk);
    #5;
    check("MDUResultW", MDUResultW, 64'h2A);
    FlushW = 1'b1;
    StallW = 1'b1;  // Flush beats stall
    @(posedge clk);
    #5;
    check("MDUResultW", MDUResultW, 64'h0);
    FlushW = 1'b0;
    StallW = 1'b0;
    StallM = 1'b0;

    // Flush in the middle of a divide
    driveE(opDiv, 64'd1000, 64'd7, 1'b0);
    repeat (10) @(posedge clk);
    #5;
    idleE();
    FlushE = 1'b1;
    @(posedge clk);
    #5;
    FlushE = 1'b0;
    check("DivBusyE", 64'(DivBusyE), 64'h0);
    mValid = 1'b0;
    issue(opDiv, 64'd1000, 64'd7, 1'b0, 64'd142);
    issue(opRem, 64'd1000, 64'd7, 1'b0, 64'd6);
    drain();

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- mdu.f
+incdir+verif
hw/mduPkg.sv
hw/mulUnit.sv
hw/divFsm.sv
hw/divCounter.sv
hw/divDatapath.sv
hw/mdu.sv
verif/mduTb.sv

//--- Makefile
# Verilator build and run for the multiply/divide unit testbench

OBJDIR = obj_dir
LOG    = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f mdu.f --top-module mduTb -Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/VmduTb > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "No result line"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
